// ==== ili9163_controller.sv ====
// ILI9163 TFT controller top level: power-on sequencer and pixel streamer over 4-wire SPI
`timescale 1ns/1ps

module ili9163_controller
    import lcd_ctrl_pkg::*;
#(
    parameter int WAIT_CYCLES = DEFAULT_WAIT_CYCLES  // Cycles per power-on wait
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [PIXEL_W-1:0] pixel_data,
    input  logic               frame_done,
    output logic               spi_mosi,
    output logic               spi_sck,
    output logic               spi_cs,
    output logic               spi_dc,
    output logic               data_clk
);

    logic seq_done;  // Init finished, pixels may flow

    lcd_word_if cmd_link ();
    lcd_word_if pix_link ();

    init_sequencer #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_init_sequencer (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd_link.source),
        .done (seq_done)
    );

    pixel_streamer u_pixel_streamer (
        .clk        (clk),
        .rst        (rst),
        .enable     (seq_done),
        .pixel_data (pixel_data),
        .frame_done (frame_done),
        .pix        (pix_link.source),
        .data_clk   (data_clk)
    );

    spi_word_link u_spi_word_link (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd_link.sink),
        .pix      (pix_link.sink),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_dc   (spi_dc)
    );

endmodule

// ==== ili9163_pkg.sv ====
// ILI9163 command opcodes, MADCTL bits and address window limits shared by the design
package ili9163_pkg;

    // ------------------------------------------------------------------
    // Command opcodes used by the controller
    // ------------------------------------------------------------------
    typedef enum logic [7:0] {
        SWRESET   = 8'h01,  // Software reset
        SLPOUT    = 8'h11,  // Sleep out
        DISPON    = 8'h29,  // Display on
        CASET     = 8'h2A,  // Column address set
        PASET     = 8'h2B,  // Page address set
        RAMWR     = 8'h2C,  // Memory write
        MADCTL    = 8'h36,  // Memory access control
        COLMOD    = 8'h3A,  // Pixel format set
        FRMCTR1   = 8'hB1,  // Frame rate, normal mode
        DISCTRL   = 8'hB6,  // Display function control
        PWCTR1    = 8'hC0,  // Power control 1
        PWCTR2    = 8'hC1,  // Power control 2
        VMCTR1    = 8'hC5,  // VCOM control 1
        VMCTR2    = 8'hC7,  // VCOM control 2
        POWERA    = 8'hCB,  // Power control A
        POWERB    = 8'hCF,  // Power control B
        POWER_SEQ = 8'hED   // Power on sequence
    } ili9163_cmd_e;

    // ------------------------------------------------------------------
    // Memory access control bits
    // ------------------------------------------------------------------
    localparam logic [7:0] MADCTL_MY  = 8'h80;  // Bottom to top
    localparam logic [7:0] MADCTL_MX  = 8'h40;  // Right to left
    localparam logic [7:0] MADCTL_MV  = 8'h20;  // Row/column exchange
    localparam logic [7:0] MADCTL_BGR = 8'h08;  // Blue-green-red order

    // Landscape orientation sent after display on
    localparam logic [7:0] MADCTL_ROTATION = MADCTL_MX | MADCTL_MY | MADCTL_MV | MADCTL_BGR;

    // ------------------------------------------------------------------
    // Address window, both windows start at zero
    // ------------------------------------------------------------------
    localparam logic [15:0] COL_END  = 16'h013F;  // 320 columns
    localparam logic [15:0] PAGE_END = 16'h00EF;  // 240 pages

    // Words in the shortened power-on table
    localparam int INIT_TABLE_LEN = 36;

endpackage

// ==== init_sequencer.sv ====
// Power-on command sequencer: reset, register table, display on, rotation and window
`timescale 1ns/1ps

module init_sequencer
    import ili9163_pkg::*;
    import lcd_ctrl_pkg::*;
#(
    parameter int WAIT_CYCLES = DEFAULT_WAIT_CYCLES
) (
    input  logic      clk,
    input  logic      rst,
    lcd_word_if.source cmd,
    output logic      done
);

    `include "init_table.svh"

    typedef logic [$clog2(WAIT_CYCLES + 1)-1:0]    wait_t;
    typedef logic [$clog2(INIT_TABLE_LEN + 1)-1:0] idx_t;

    seq_state_e state_q;
    idx_t       idx_q;      // Init table position
    wait_t      wait_q;
    logic [3:0] step_q;     // Rotation and window word
    logic       req_q;
    logic       pend_q;     // Word issued, ack not yet fallen
    lcd_word_t  word_q;
    lcd_word_t  next_word;
    logic       sending;
    logic       waiting;

    assign cmd.req  = req_q;
    assign cmd.word = word_q;
    assign done     = (state_q == DONE);

    assign sending = state_q inside {RESET_CMD, INIT_TABLE, DISPLAY_ON, ROTATION, WINDOW};
    assign waiting = state_q inside {WAIT_RESET, WAIT_INIT, WAIT_ON};

    // ------------------------------------------------------------------
    // Word for the current step
    // ------------------------------------------------------------------
    always_comb begin
        next_word = '{dc: 1'b0, data: SWRESET};
        case (state_q)
            INIT_TABLE: next_word = INIT_WORDS[idx_q];
            DISPLAY_ON: next_word = '{dc: 1'b0, data: DISPON};
            ROTATION: begin
                if (step_q == 4'd0) next_word = '{dc: 1'b0, data: MADCTL};
                else                next_word = '{dc: 1'b1, data: MADCTL_ROTATION};
            end
            WINDOW: begin
                case (step_q)
                    4'd0:    next_word = '{dc: 1'b0, data: CASET};
                    4'd3:    next_word = '{dc: 1'b1, data: COL_END[15:8]};
                    4'd4:    next_word = '{dc: 1'b1, data: COL_END[7:0]};
                    4'd5:    next_word = '{dc: 1'b0, data: PASET};
                    4'd8:    next_word = '{dc: 1'b1, data: PAGE_END[15:8]};
                    4'd9:    next_word = '{dc: 1'b1, data: PAGE_END[7:0]};
                    4'd10:   next_word = '{dc: 1'b0, data: RAMWR};
                    default: next_word = '{dc: 1'b1, data: 8'h00};  // Window start bytes
                endcase
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // Sequence and handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RESET_CMD;
            idx_q   <= '0;
            wait_q  <= '0;
            step_q  <= '0;
            req_q   <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            if (req_q && cmd.ack) req_q <= 1'b0;  // Phase 3

            if (waiting) begin
                if (wait_q == wait_t'(WAIT_CYCLES - 1)) begin
                    wait_q <= '0;
                    case (state_q)
                        WAIT_RESET: state_q <= INIT_TABLE;
                        WAIT_INIT:  state_q <= DISPLAY_ON;
                        default:    state_q <= ROTATION;
                    endcase
                end else begin
                    wait_q <= wait_q + 1'b1;
                end
            end

            if (sending && !pend_q) begin
                word_q <= next_word;
                req_q  <= 1'b1;
                pend_q <= 1'b1;
            end else if (sending && !req_q && !cmd.ack) begin  // Ack has fallen
                pend_q <= 1'b0;
                case (state_q)
                    RESET_CMD:  state_q <= WAIT_RESET;
                    DISPLAY_ON: state_q <= WAIT_ON;
                    INIT_TABLE: begin
                        if (idx_q == idx_t'(INIT_TABLE_LEN - 1)) begin
                            idx_q   <= '0;
                            state_q <= WAIT_INIT;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                    ROTATION: begin
                        if (step_q == 4'd1) begin  // Argument sent
                            step_q  <= '0;
                            state_q <= WINDOW;
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end
                    default: begin
                        if (step_q == 4'd10) begin  // RAMWR sent
                            step_q  <= '0;
                            state_q <= DONE;
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== init_table.svh ====
// Shortened ILI9163 power-on register table, included into the init sequencer body
`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

localparam lcd_word_t INIT_WORDS [INIT_TABLE_LEN] = '{
    '{1'b0, POWERA},     // Power control A
    '{1'b1, 8'h39},
    '{1'b1, 8'h2C},
    '{1'b1, 8'h00},
    '{1'b1, 8'h34},
    '{1'b1, 8'h02},
    '{1'b0, POWERB},     // Power control B
    '{1'b1, 8'h00},
    '{1'b1, 8'hC1},
    '{1'b1, 8'h30},
    '{1'b0, POWER_SEQ},  // Power on sequence
    '{1'b1, 8'h64},
    '{1'b1, 8'h03},
    '{1'b1, 8'h12},
    '{1'b1, 8'h81},
    '{1'b0, PWCTR1},     // GVDD level
    '{1'b1, 8'h23},
    '{1'b0, PWCTR2},
    '{1'b1, 8'h10},
    '{1'b0, VMCTR1},     // VCOMH and VCOML
    '{1'b1, 8'h3E},
    '{1'b1, 8'h28},
    '{1'b0, VMCTR2},
    '{1'b1, 8'h86},
    '{1'b0, MADCTL},     // Portrait until rotation step
    '{1'b1, 8'h48},
    '{1'b0, COLMOD},     // 16 bits per pixel
    '{1'b1, 8'h55},
    '{1'b0, FRMCTR1},
    '{1'b1, 8'h00},
    '{1'b1, 8'h18},
    '{1'b0, DISCTRL},
    '{1'b1, 8'h08},
    '{1'b1, 8'h82},
    '{1'b1, 8'h27},
    '{1'b0, SLPOUT}      // Leave sleep, needs the long wait
};

`endif

// ==== lcd_ctrl_pkg.sv ====
// Link word type, sequencer states and SPI timing shared by the controller blocks
package lcd_ctrl_pkg;

    // ------------------------------------------------------------------
    // One word on the display link
    // ------------------------------------------------------------------
    typedef struct packed {
        logic       dc;    // 1 = data, 0 = command
        logic [7:0] data;  // Byte shifted out MSB first
    } lcd_word_t;

    // ------------------------------------------------------------------
    // Power-on sequencer states
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        RESET_CMD,   // Software reset command
        WAIT_RESET,
        INIT_TABLE,  // Register table
        WAIT_INIT,
        DISPLAY_ON,
        WAIT_ON,
        ROTATION,    // MADCTL and its argument
        WINDOW,      // CASET, PASET and RAMWR
        DONE
    } seq_state_e;

    localparam int PIXEL_W  = 16;  // RGB565
    localparam int SCK_HALF = 1;   // Clocks per SCK half period

    // 100 ms at 25 MHz
    localparam int DEFAULT_WAIT_CYCLES = 2500000;

endpackage

// ==== lcd_word_if.sv ====
// Display word channel with a four-phase req/ack handshake, one per word source
`timescale 1ns/1ps

interface lcd_word_if
    import lcd_ctrl_pkg::*;
();

    logic      req;   // Word valid, held until ack
    logic      ack;   // Word fully shifted out
    lcd_word_t word;  // Stable while req is high

    modport source (
        output req,
        output word,
        input  ack
    );

    modport sink (
        input  req,
        input  word,
        output ack
    );

endinterface

// ==== pixel_streamer.sv ====
// Pixel streamer: sends each pixel as high then low data byte once init is done
`timescale 1ns/1ps

module pixel_streamer
    import lcd_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,      // Sequencer done
    input  logic [PIXEL_W-1:0] pixel_data,
    input  logic               frame_done,  // Pause request
    lcd_word_if.source         pix,
    output logic               data_clk
);

    logic      req_q;
    logic      pend_q;     // Word issued, ack not yet fallen
    logic      low_q;      // Next byte is the low byte
    logic [1:0] settle_q;  // Host update time after data_clk edges
    lcd_word_t word_q;

    assign pix.req  = req_q;
    assign pix.word = word_q;

    // High between the two bytes of a pixel
    assign data_clk = low_q;

    // ------------------------------------------------------------------
    // Byte issue and handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q    <= 1'b0;
            pend_q   <= 1'b0;
            low_q    <= 1'b0;
            settle_q <= '0;
        end else begin
            if (req_q && pix.ack) req_q <= 1'b0;
            if (settle_q != 2'd0) settle_q <= settle_q - 1'b1;

            if (!pend_q) begin
                // Word in flight always finishes, only new ones wait
                if (enable && !frame_done && settle_q == 2'd0) begin
                    word_q.dc <= 1'b1;
                    if (low_q) word_q.data <= pixel_data[7:0];
                    else       word_q.data <= pixel_data[PIXEL_W-1 -: 8];
                    req_q  <= 1'b1;
                    pend_q <= 1'b1;
                end
            end else if (!req_q && !pix.ack) begin
                pend_q   <= 1'b0;
                low_q    <= ~low_q;  // Toggles data_clk
                settle_q <= 2'd2;    // Pixel sampled two clocks later at the earliest
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ILI9163 controller testbench with Verilator, runs it and checks for a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_ili9163 -o tb_ili9163
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_ili9163 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "No errors"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// ==== sim.f ====
+incdir+.
ili9163_pkg.sv
lcd_ctrl_pkg.sv
lcd_word_if.sv
init_sequencer.sv
pixel_streamer.sv
spi_word_link.sv
ili9163_controller.sv
tb_ili9163_assert.sv
tb_ili9163.sv

// ==== spi_word_link.sv ====
// SPI link: arbitrates command and pixel words and shifts the granted word out
`timescale 1ns/1ps

module spi_word_link
    import lcd_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    lcd_word_if.sink cmd,
    lcd_word_if.sink pix,
    output logic     spi_mosi,
    output logic     spi_sck,
    output logic     spi_cs,
    output logic     spi_dc
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_SHIFT,
        L_GAP,   // cs high before ack
        L_ACK    // Waiting for req to drop
    } link_state_e;

    typedef logic [$clog2(SCK_HALF + 1)-1:0] div_t;

    link_state_e state_q;
    logic        grant_pix_q;  // 0 = command source
    logic        ack_q;
    logic [6:0]  shift_q;      // Bits still to send
    logic [2:0]  bit_q;
    div_t        div_q;
    lcd_word_t   sel_word;

    // Command source wins a tie
    assign sel_word = cmd.req ? cmd.word : pix.word;

    assign cmd.ack = ack_q & ~grant_pix_q;
    assign pix.ack = ack_q & grant_pix_q;

    // ------------------------------------------------------------------
    // Grant, shifter and SCK generation
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= L_IDLE;
            grant_pix_q <= 1'b0;
            ack_q       <= 1'b0;
            bit_q       <= '0;
            div_q       <= '0;
            spi_mosi    <= 1'b0;
            spi_sck     <= 1'b0;
            spi_cs      <= 1'b1;
            spi_dc      <= 1'b0;
        end else begin
            case (state_q)
                L_IDLE: begin
                    if (cmd.req || pix.req) begin
                        grant_pix_q <= ~cmd.req;
                        shift_q     <= sel_word.data[6:0];
                        spi_mosi    <= sel_word.data[7];  // MSB first
                        spi_dc      <= sel_word.dc;
                        spi_cs      <= 1'b0;
                        bit_q       <= '0;
                        div_q       <= '0;
                        state_q     <= L_SHIFT;
                    end
                end
                L_SHIFT: begin
                    if (div_q == div_t'(SCK_HALF - 1)) begin
                        div_q <= '0;
                        if (!spi_sck) begin
                            spi_sck <= 1'b1;  // Display samples here
                        end else begin
                            spi_sck <= 1'b0;
                            if (bit_q == 3'd7) begin
                                spi_cs  <= 1'b1;
                                state_q <= L_GAP;
                            end else begin
                                bit_q    <= bit_q + 1'b1;
                                spi_mosi <= shift_q[6];
                                shift_q  <= {shift_q[5:0], 1'b0};
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                L_GAP: begin
                    ack_q   <= 1'b1;
                    state_q <= L_ACK;
                end
                default: begin
                    // Grant released once ack has dropped
                    if (!(grant_pix_q ? pix.req : cmd.req)) begin
                        ack_q   <= 1'b0;
                        state_q <= L_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== tb_ili9163.sv ====
// Directed testbench for the ILI9163 controller that decodes the SPI pins and checks every word
`timescale 1ns/1ps

module tb_ili9163
    import ili9163_pkg::*;
    import lcd_ctrl_pkg::*;
();

    localparam int WAIT_CYCLES = 50;                  // Short power-on waits
    localparam int CMD_WORDS   = INIT_TABLE_LEN + 15;  // Reset, table, on, rotation, window
    localparam int PIXELS      = 8;
    localparam int TIMEOUT_CYCLES = 3 * (WAIT_CYCLES + 20)
                                  + 30 * (2 * CMD_WORDS + 2 * PIXELS + 8) + 500;

    // Power-on register table with dc in bit 8
    localparam logic [8:0] INIT_EXP [INIT_TABLE_LEN] = '{
        9'h0CB, 9'h139, 9'h12C, 9'h100, 9'h134, 9'h102,
        9'h0CF, 9'h100, 9'h1C1, 9'h130,
        9'h0ED, 9'h164, 9'h103, 9'h112, 9'h181,
        9'h0C0, 9'h123, 9'h0C1, 9'h110,
        9'h0C5, 9'h13E, 9'h128, 9'h0C7, 9'h186,
        9'h036, 9'h148, 9'h03A, 9'h155,
        9'h0B1, 9'h100, 9'h118,
        9'h0B6, 9'h108, 9'h182, 9'h127,
        9'h011
    };

    logic               clk = 1'b0;
    logic               rst;
    logic [PIXEL_W-1:0] pixel_data;
    logic               frame_done;
    logic               spi_mosi;
    logic               spi_sck;
    logic               spi_cs;
    logic               spi_dc;
    logic               data_clk;

    logic [8:0]  rx_words [$];  // Decoded {dc, byte}
    int          rx_gaps [$];   // Cycles cs was high before each word
    logic [8:0]  exp_cmds [$];
    logic [15:0] exp_pix [$];   // Pixels in hand-over order
    logic [7:0]  shift_in;
    logic        dc_in;
    logic        sck_d;
    logic        cs_d;
    logic        dclk_d;
    int          bit_cnt = 0;
    int          high_cnt = 0;
    int          cs_falls = 0;
    int          dclk_toggles = 0;
    int          cycle_cnt = 0;
    int          errors = 0;

    ili9163_controller #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .pixel_data (pixel_data),
        .frame_done (frame_done),
        .spi_mosi   (spi_mosi),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_dc     (spi_dc),
        .data_clk   (data_clk)
    );

    bind spi_word_link tb_spi_assert u_spi_assert (
        .clk      (clk),
        .rst      (rst),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .cmd_req  (cmd.req),
        .cmd_ack  (cmd.ack),
        .pix_req  (pix.req),
        .pix_ack  (pix.ack)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // SPI decoder, host pixel source and run limit
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        sck_d  <= spi_sck;
        cs_d   <= spi_cs;
        dclk_d <= data_clk;
        if (rst) begin
            bit_cnt  <= 0;
            high_cnt <= 0;
        end else begin
            if (spi_cs) high_cnt <= high_cnt + 1;
            if (cs_d && !spi_cs) begin  // Word starts
                rx_gaps.push_back(high_cnt);
                cs_falls <= cs_falls + 1;
                high_cnt <= 0;
                bit_cnt  <= 0;
            end
            if (spi_sck && !sck_d) begin
                shift_in <= {shift_in[6:0], spi_mosi};
                dc_in    <= spi_dc;
                bit_cnt  <= bit_cnt + 1;
            end
            if (spi_cs && !cs_d && bit_cnt == 8) rx_words.push_back({dc_in, shift_in});
            if (data_clk != dclk_d) dclk_toggles <= dclk_toggles + 1;
        end
    end

    always @(posedge clk) begin
        if (dclk_d && !data_clk) hand_over_pixel();  // Previous pixel consumed
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Words decoded: %0d, errors: %0d", rx_words.size(), errors);
            $display("Errors found");
            $finish;
        end
    end

    task automatic hand_over_pixel();
        logic [15:0] pix;
        pix = 16'($urandom);
        exp_pix.push_back(pix);
        pixel_data <= pix;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED at %0d ns: %s expected %0h, got %0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic push_window(input logic [15:0] last);
        exp_cmds.push_back(9'h100);  // Window starts at zero
        exp_cmds.push_back(9'h100);
        exp_cmds.push_back({1'b1, last[15:8]});
        exp_cmds.push_back({1'b1, last[7:0]});
    endtask

    task automatic build_expected();
        int i;
        exp_cmds.push_back({1'b0, SWRESET});
        for (i = 0; i < INIT_TABLE_LEN; i++) begin
            exp_cmds.push_back(INIT_EXP[i]);
        end
        exp_cmds.push_back({1'b0, DISPON});
        exp_cmds.push_back({1'b0, MADCTL});
        exp_cmds.push_back({1'b1, 8'hE8});  // MX, MY, MV and BGR set
        exp_cmds.push_back({1'b0, CASET});
        push_window(16'h013F);
        exp_cmds.push_back({1'b0, PASET});
        push_window(16'h00EF);
        exp_cmds.push_back({1'b0, RAMWR});
    endtask

    task automatic check_idle_pins();
        if (spi_cs !== 1'b1) report_mismatch("spi_cs", 1, spi_cs);
        if (spi_sck !== 1'b0) report_mismatch("spi_sck", 0, spi_sck);
        if (spi_mosi !== 1'b0) report_mismatch("spi_mosi", 0, spi_mosi);
        if (spi_dc !== 1'b0) report_mismatch("spi_dc", 0, spi_dc);
        if (data_clk !== 1'b0) report_mismatch("data_clk", 0, data_clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_idle_pins();
        @(posedge clk);
        rst <= 1'b0;
    endtask

    // High byte first and both bytes with dc set
    task automatic check_pixel_word(input int k);
        int         p;
        logic [8:0] exp;
        p = (k - CMD_WORDS) / 2;
        if (p >= exp_pix.size()) begin
            report_failure($sformatf("pixel byte %0d arrived before its pixel was handed over",
                                     k));
        end else begin
            if ((k - CMD_WORDS) % 2 == 0) exp = {1'b1, exp_pix[p][15:8]};
            else                          exp = {1'b1, exp_pix[p][7:0]};
            if (rx_words[k] !== exp)
                report_mismatch($sformatf("pixel byte %0d {dc,byte}", k - CMD_WORDS),
                                exp, rx_words[k]);
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic verify_reset_state();
        int n;
        apply_reset();
        @(negedge clk);
        check_idle_pins();
        n = 0;
        while (spi_cs && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (spi_cs) report_failure("first command did not reach the SPI pins within 8 cycles");
    endtask

    task automatic compare_command_stream();
        int i;
        while (rx_words.size() < CMD_WORDS) @(negedge clk);
        for (i = 0; i < CMD_WORDS; i++) begin
            if (rx_words[i] !== exp_cmds[i])
                report_mismatch($sformatf("command word %0d {dc,byte}", i),
                                exp_cmds[i], rx_words[i]);
        end
    endtask

    task automatic measure_power_on_waits();
        if (rx_gaps[1] < WAIT_CYCLES)
            report_failure($sformatf("wait after SWRESET only %0d cycles", rx_gaps[1]));
        if (rx_gaps[INIT_TABLE_LEN + 1] < WAIT_CYCLES)
            report_failure($sformatf("wait after init table only %0d cycles",
                                     rx_gaps[INIT_TABLE_LEN + 1]));
        if (rx_gaps[INIT_TABLE_LEN + 2] < WAIT_CYCLES)
            report_failure($sformatf("wait after DISPON only %0d cycles",
                                     rx_gaps[INIT_TABLE_LEN + 2]));
    endtask

    task automatic stream_random_pixels();
        int i;
        while (dclk_toggles < 2 * PIXELS) @(negedge clk);
        if (rx_words.size() != CMD_WORDS + 2 * PIXELS)
            report_mismatch("pixel bytes per data_clk toggles", 2 * PIXELS,
                            rx_words.size() - CMD_WORDS);
        for (i = CMD_WORDS; i < rx_words.size(); i++) begin
            check_pixel_word(i);
        end
    endtask

    task automatic pause_on_frame_done();
        int falls0;
        int words0;
        int i;
        @(posedge clk);
        frame_done <= 1'b1;
        falls0 = cs_falls;
        repeat (40) @(negedge clk);  // Word in flight completes
        if (cs_falls - falls0 > 1)
            report_failure("more than one word started after frame_done rose");
        falls0 = cs_falls;
        repeat (100) @(negedge clk);
        if (cs_falls != falls0) report_failure("a word started while frame_done was high");
        words0 = rx_words.size();
        @(posedge clk);
        frame_done <= 1'b0;
        while (rx_words.size() == words0) @(negedge clk);
        for (i = CMD_WORDS; i < rx_words.size(); i++) begin
            check_pixel_word(i);
        end
    endtask

    task automatic reset_during_stream();
        int base;
        while (spi_cs) @(negedge clk);
        repeat (4) @(negedge clk);  // Partway through a pixel byte
        apply_reset();
        base = rx_words.size();
        while (rx_words.size() == base) @(negedge clk);
        if (rx_words[base] !== {1'b0, SWRESET})
            report_mismatch("first word after reset {dc,byte}", {1'b0, SWRESET},
                            rx_words[base]);
    endtask

    initial begin
        void'($urandom(32'h8cf42b5b));
        rst        = 1'b1;
        frame_done = 1'b0;
        hand_over_pixel();
        build_expected();
        verify_reset_state();
        compare_command_stream();
        measure_power_on_waits();
        stream_random_pixels();
        pause_on_frame_done();
        reset_during_stream();
        $display("Words decoded: %0d, errors: %0d", rx_words.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb_ili9163_assert.sv ====
// SPI pin and word handshake assertions, bound into the SPI link by the testbench
`timescale 1ns/1ps

module tb_spi_assert (
    input logic clk,
    input logic rst,
    input logic spi_cs,
    input logic spi_sck,
    input logic spi_mosi,
    input logic cmd_req,
    input logic cmd_ack,
    input logic pix_req,
    input logic pix_ack
);

    // ------------------------------------------------------------------
    // SPI pins
    // ------------------------------------------------------------------
    sck_low_when_idle: assert property (@(posedge clk) disable iff (rst) spi_cs |-> !spi_sck)
        else $error("spi_sck is high while spi_cs is high");

    // Display samples on the rising edge, so the bit must not move while sck is high
    mosi_stable_sck_high: assert property (@(posedge clk) disable iff (rst)
        spi_sck |-> $stable(spi_mosi))
        else $error("spi_mosi changed while spi_sck is high");

    // ------------------------------------------------------------------
    // Four-phase handshake on both word sources
    // ------------------------------------------------------------------
    cmd_ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(cmd_ack) |-> cmd_req)
        else $error("command ack rose without a request");

    pix_ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(pix_ack) |-> pix_req)
        else $error("pixel ack rose without a request");

    cmd_req_held: assert property (@(posedge clk) disable iff (rst) (cmd_req && !cmd_ack) |=> cmd_req)
        else $error("command request dropped before ack");

    pix_req_held: assert property (@(posedge clk) disable iff (rst) (pix_req && !pix_ack) |=> pix_req)
        else $error("pixel request dropped before ack");

endmodule
